//--- design/backend_top.sv
`timescale 1ns/1ns

module backend_top
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // instruction from the exec stage
    input  logic        ex_valid,
    input  logic        ex_reg_write,
    input  logic        ex_fpu_reg_write,
    input  logic        ex_mem_write,
    input  result_src_t ex_result_src,
    input  reg_addr_t   ex_rd,
    input  word_t       ex_alu_result,
    input  word_t       ex_write_data,
    input  word_t       ex_pc_plus4,
    input  word_t       ex_rd1,
    input  word_t       ex_imm_ext,
    input  word_t       ex_fpu_rd1,
    input  word_t       ex_fpu_result,

    // branch outcome and sequential pc
    input  logic        pc_src_e,
    input  word_t       pc_target_e,
    input  word_t       pc_plus4_f,

    // input device
    input  word_t       dev_data,
    input  logic        dev_valid,
    output logic        dev_ready,

    output logic        in_stall,
    output word_t       instr_addr,

    // register read ports for decode
    input  reg_addr_t   rs1_addr,
    output word_t       rs1_data,
    input  reg_addr_t   rs2_addr,
    output word_t       rs2_data,
    input  reg_addr_t   fs1_addr,
    output word_t       fs1_data
);
    logic        mem_valid;
    result_src_t mem_result_src;
    word_t       in_data;
    logic        reg_write_w;
    logic        fpu_reg_write_w;
    reg_addr_t   rd_w;
    word_t       result_w;

    control_mem_io control_mem_if ();
    data_mem_io    data_mem_if ();

    mem_stage mem_stage_i (
        .clk, .rst, .in_stall,
        .ex_valid, .ex_reg_write, .ex_fpu_reg_write, .ex_mem_write,
        .ex_result_src, .ex_rd, .ex_alu_result, .ex_write_data,
        .ex_pc_plus4, .ex_rd1, .ex_imm_ext, .ex_fpu_rd1, .ex_fpu_result,
        .control_mem_if (control_mem_if.out),
        .data_mem_if    (data_mem_if.out),
        .mem_result_src, .mem_valid
    );

    // runs beside the memory stage and feeds write-back with in_data
    in_port in_port_i (
        .clk, .rst, .dev_data, .dev_valid, .dev_ready,
        .mem_valid, .mem_result_src, .in_stall, .in_data
    );

    write_back write_back_i (
        .control_mem_if (control_mem_if.in),
        .data_mem_if    (data_mem_if.in),
        .in_data, .pc_src_e, .pc_target_e, .pc_plus4_f,
        .reg_write_w, .fpu_reg_write_w, .rd_w, .result_w, .instr_addr
    );

    reg_banks reg_banks_i (
        .clk, .rst, .reg_write_w, .fpu_reg_write_w, .rd_w, .result_w,
        .rs1_addr, .rs2_addr, .fs1_addr, .rs1_data, .rs2_data, .fs1_data
    );
endmodule

//--- design/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    // one data word, as held in a register or in the data RAM
    typedef logic [`CORE_XLEN-1:0] word_t;

    // index into either register bank
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;

    // word index into the data RAM
    // mem_stage takes it from bits 9:2 of the ALU result
    typedef logic [$clog2(`CORE_DMEM_WORDS)-1:0] dmem_addr_t;

    // source of the value written back to a register
    // the encoding matches the result_src field produced by decode
    typedef enum logic [2:0] {
        // arithmetic result from the ALU
        RES_ALU     = 3'b000,
        // word read from the data RAM
        RES_LOAD    = 3'b001,
        // return address for jal and jalr
        RES_PC4     = 3'b010,
        // integer source register moved unchanged
        RES_RD1     = 3'b011,
        // immediate for lui
        RES_IMM     = 3'b100,
        // FPU source register moved unchanged, as for fmv
        RES_FPU_RD1 = 3'b101,
        // result from the FPU arithmetic
        RES_FPU     = 3'b110,
        // word taken from the input device
        RES_IN      = 3'b111
    } result_src_t;

endpackage

//--- design/in_port.sv
`timescale 1ns/1ns

module in_port
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // valid/ready handshake with the input device
    input  word_t       dev_data,
    input  logic        dev_valid,
    output logic        dev_ready,

    // instruction currently held in EX/MEM
    input  logic        mem_valid,
    input  result_src_t mem_result_src,

    output logic        in_stall,
    output word_t       in_data
);
    word_t       fifo_mem [2];
    logic        wr_ptr;
    logic        rd_ptr;
    // number of buffered words, 0 to 2
    logic [1:0]  count;
    logic        push;
    logic        pop;
    logic        take;

    assign dev_ready = (count != 2'd2);
    assign push      = dev_valid && dev_ready;

    // an in instruction wants to leave EX/MEM on the next edge
    assign take     = mem_valid && (mem_result_src == RES_IN);
    // no bypass from dev_data, the word has to be buffered first
    assign in_stall = take && (count == 2'd0);
    assign pop      = take && (count != 2'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= dev_data;
        end
        // loaded on the same edge the in instruction enters MEM/WB
        // and left alone until the next in instruction follows it
        if (pop) begin
            in_data <= fifo_mem[rd_ptr];
        end
    end
endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ns
`include "core_macros.svh"

module mem_stage
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_stall,

    // instruction leaving the exec stage
    input  logic        ex_valid,
    input  logic        ex_reg_write,
    input  logic        ex_fpu_reg_write,
    input  logic        ex_mem_write,
    input  result_src_t ex_result_src,
    input  reg_addr_t   ex_rd,
    input  word_t       ex_alu_result,
    input  word_t       ex_write_data,
    input  word_t       ex_pc_plus4,
    input  word_t       ex_rd1,
    input  word_t       ex_imm_ext,
    input  word_t       ex_fpu_rd1,
    input  word_t       ex_fpu_result,

    // MEM/WB register towards write-back
    control_mem_io.out  control_mem_if,
    data_mem_io.out     data_mem_if,

    // EX/MEM view for the input port
    output result_src_t mem_result_src,
    output logic        mem_valid
);
    // EX/MEM control bits
    logic        exm_valid;
    logic        exm_reg_write;
    logic        exm_fpu_reg_write;
    logic        exm_mem_write;
    result_src_t exm_result_src;

    // EX/MEM payload
    reg_addr_t   exm_rd;
    word_t       exm_alu_result;
    word_t       exm_write_data;
    word_t       exm_pc_plus4;
    word_t       exm_rd1;
    word_t       exm_imm_ext;
    word_t       exm_fpu_rd1;
    word_t       exm_fpu_result;

    word_t       dmem [`CORE_DMEM_WORDS];
    dmem_addr_t  dmem_addr;
    word_t       read_data;

    // while stalled the EX/MEM register keeps the waiting in instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            exm_valid         <= 1'b0;
            exm_reg_write     <= 1'b0;
            exm_fpu_reg_write <= 1'b0;
            exm_mem_write     <= 1'b0;
            exm_result_src    <= RES_ALU;
        end else if (!in_stall) begin
            exm_valid         <= ex_valid;
            exm_reg_write     <= ex_reg_write;
            exm_fpu_reg_write <= ex_fpu_reg_write;
            exm_mem_write     <= ex_mem_write;
            exm_result_src    <= ex_result_src;
        end
    end

    always_ff @(posedge clk) begin
        if (!in_stall) begin
            exm_rd         <= ex_rd;
            exm_alu_result <= ex_alu_result;
            exm_write_data <= ex_write_data;
            exm_pc_plus4   <= ex_pc_plus4;
            exm_rd1        <= ex_rd1;
            exm_imm_ext    <= ex_imm_ext;
            exm_fpu_rd1    <= ex_fpu_rd1;
            exm_fpu_result <= ex_fpu_result;
        end
    end

    // only whole words are accessed, so the two low address bits are dropped
    assign dmem_addr = exm_alu_result[$bits(dmem_addr_t)+1:2];
    assign read_data = dmem[dmem_addr];

    // a store commits on the edge that moves it into MEM/WB
    always_ff @(posedge clk) begin
        if (exm_valid && exm_mem_write && !in_stall) begin
            dmem[dmem_addr] <= exm_write_data;
        end
    end

    // a stall sends a bubble to write-back so the in instruction is not repeated
    always_ff @(posedge clk) begin
        if (rst || in_stall) begin
            control_mem_if.valid         <= 1'b0;
            control_mem_if.reg_write     <= 1'b0;
            control_mem_if.fpu_reg_write <= 1'b0;
            control_mem_if.result_src    <= RES_ALU;
        end else begin
            control_mem_if.valid         <= exm_valid;
            control_mem_if.reg_write     <= exm_reg_write;
            control_mem_if.fpu_reg_write <= exm_fpu_reg_write;
            control_mem_if.result_src    <= exm_result_src;
        end
    end

    // payload follows along every cycle, a bubble makes it irrelevant
    always_ff @(posedge clk) begin
        data_mem_if.rd         <= exm_rd;
        data_mem_if.alu_result <= exm_alu_result;
        data_mem_if.read_data  <= read_data;
        data_mem_if.pc_plus4   <= exm_pc_plus4;
        data_mem_if.rd1        <= exm_rd1;
        data_mem_if.imm_ext    <= exm_imm_ext;
        data_mem_if.fpu_rd1    <= exm_fpu_rd1;
        data_mem_if.fpu_result <= exm_fpu_result;
    end

    assign mem_valid      = exm_valid;
    assign mem_result_src = exm_result_src;
endmodule

//--- design/pipe_if.sv
`timescale 1ns/1ns

// control bits of the instruction that sits in the MEM/WB register
interface control_mem_io
    import core_pkg::*;
();
    // low for a bubble, which gates every write enable in write-back
    logic        valid;
    logic        reg_write;
    logic        fpu_reg_write;
    result_src_t result_src;

    // mem_stage owns the MEM/WB register and drives these bits
    modport out (
        output valid, reg_write, fpu_reg_write, result_src
    );

    // write-back consumes them
    modport in (
        input valid, reg_write, fpu_reg_write, result_src
    );
endinterface

// data fields of the same instruction, one per possible result source
interface data_mem_io
    import core_pkg::*;
();
    reg_addr_t rd;
    word_t     alu_result;
    word_t     read_data;
    word_t     pc_plus4;
    word_t     rd1;
    word_t     imm_ext;
    word_t     fpu_rd1;
    word_t     fpu_result;

    modport out (
        output rd, alu_result, read_data, pc_plus4, rd1, imm_ext, fpu_rd1, fpu_result
    );

    modport in (
        input rd, alu_result, read_data, pc_plus4, rd1, imm_ext, fpu_rd1, fpu_result
    );
endinterface

//--- design/reg_banks.sv
`timescale 1ns/1ns
`include "core_macros.svh"

module reg_banks
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // shared write port from write-back, one enable per bank
    input  logic      reg_write_w,
    input  logic      fpu_reg_write_w,
    input  reg_addr_t rd_w,
    input  word_t     result_w,

    // read ports used by decode
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t fs1_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output word_t     fs1_data
);
    word_t int_regs [`CORE_NREGS];
    word_t fpu_regs [`CORE_NREGS];

    // integer bank, x0 is hardwired and drops its writes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                int_regs[i] <= '0;
            end
        end else if (reg_write_w && (rd_w != '0)) begin
            int_regs[rd_w] <= result_w;
        end
    end

    // FPU bank, every register including f0 is writable
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                fpu_regs[i] <= '0;
            end
        end else if (fpu_reg_write_w) begin
            fpu_regs[rd_w] <= result_w;
        end
    end

    // reads are combinational, a write shows up right after its edge
    // decode samples them in the cycle that follows write-back
    assign rs1_data = (rs1_addr == '0) ? '0 : int_regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : int_regs[rs2_addr];
    assign fs1_data = fpu_regs[fs1_addr];
endmodule

//--- design/write_back.sv
`timescale 1ns/1ns

module write_back
    import core_pkg::*;
(
    // MEM/WB register
    control_mem_io.in control_mem_if,
    data_mem_io.in    data_mem_if,

    // word popped by the input port for an in instruction
    input  word_t     in_data,

    // branch outcome from exec and the sequential pc from fetch
    input  logic      pc_src_e,
    input  word_t     pc_target_e,
    input  word_t     pc_plus4_f,

    // write port of the register banks
    output logic      reg_write_w,
    output logic      fpu_reg_write_w,
    output reg_addr_t rd_w,
    output word_t     result_w,

    // next fetch address to the instruction memory
    output word_t     instr_addr
);
    // a bubble must never write either bank
    assign reg_write_w     = control_mem_if.valid && control_mem_if.reg_write;
    assign fpu_reg_write_w = control_mem_if.valid && control_mem_if.fpu_reg_write;
    assign rd_w            = data_mem_if.rd;

    always_comb begin
        case (control_mem_if.result_src)
            RES_ALU:     result_w = data_mem_if.alu_result;
            RES_LOAD:    result_w = data_mem_if.read_data;
            RES_PC4:     result_w = data_mem_if.pc_plus4;
            RES_RD1:     result_w = data_mem_if.rd1;
            RES_IMM:     result_w = data_mem_if.imm_ext;
            RES_FPU_RD1: result_w = data_mem_if.fpu_rd1;
            RES_FPU:     result_w = data_mem_if.fpu_result;
            RES_IN:      result_w = in_data;
            default:     result_w = '0;
        endcase
    end

    // taken branches and jumps redirect fetch in the same cycle
    // fetch and exec hold their values during a stall, so this stays steady
    assign instr_addr = pc_src_e ? pc_target_e : pc_plus4_f;
endmodule

//--- filelist.f
+incdir+include
design/core_pkg.sv
design/pipe_if.sv
design/mem_stage.sv
design/in_port.sv
design/write_back.sv
design/reg_banks.sv
design/backend_top.sv
tests/backend_checker.sv
tests/backend_tb.sv

//--- include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// width of one data word and of every register in both banks
`define CORE_XLEN 32

// registers per bank, used for both the integer and the FPU bank
`define CORE_NREGS 32

// depth of the word-addressed data RAM
// a power of two, so the RAM index is a plain bit slice of the address
`define CORE_DMEM_WORDS 256

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# compile the testbench with Verilator, run it and judge the log
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f filelist.f \
    --top-module backend_tb -o backend_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

# assertion errors must not stop the run before the summary is printed
./obj_dir/backend_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

//--- tests/backend_checker.sv
`timescale 1ns/1ns

module backend_checker
    import core_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        mem_valid,
    input logic        in_stall,
    input logic        wb_valid,
    input result_src_t wb_src,
    input logic        reg_write_w,
    input logic        fpu_reg_write_w,
    input logic        dev_ready,
    input logic [1:0]  fifo_count,
    input word_t       in_data
);
    // number of assertion failures seen so far
    int unsigned assert_fails = 0;

    // a stall keeps the in instruction in EX/MEM and sends a bubble to MEM/WB
    stall_inserts_bubble: assert property (@(posedge clk) disable iff (rst)
        in_stall |=> (mem_valid && !wb_valid))
    else begin
        assert_fails++;
        $error("a stall did not hold EX/MEM or did not send a bubble to MEM/WB");
    end

    // a write enable in write-back only follows a valid instruction
    // that left EX/MEM on the previous edge without a stall
    write_follows_instr: assert property (@(posedge clk) disable iff (rst)
        (reg_write_w || fpu_reg_write_w) |-> $past(mem_valid && !in_stall))
    else begin
        assert_fails++;
        $error("a write enable is high without a valid instruction from EX/MEM");
    end

    // the buffer gains at most one word per edge, so a cycle after being empty it has room
    empty_fifo_ready: assert property (@(posedge clk) disable iff (rst)
        (fifo_count == 2'd0) |=> dev_ready)
    else begin
        assert_fails++;
        $error("dev_ready is low one cycle after the input buffer was empty");
    end

    // in_data moves only on the edge that brings an in instruction into write-back
    in_data_steady: assert property (@(posedge clk) disable iff (rst)
        !$stable(in_data) |-> (wb_valid && wb_src == RES_IN))
    else begin
        assert_fails++;
        $error("in_data changed without an in instruction entering write-back");
    end
endmodule

//--- tests/backend_tb.sv
`timescale 1ns/1ns
`include "core_macros.svh"

module backend_tb
    import core_pkg::*;
();
    localparam int CLK_PERIOD = 40;

    // one instruction of the table together with what it should leave behind
    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        fpu_reg_write;
        logic        mem_write;
        result_src_t src;
        reg_addr_t   rd;
        word_t       alu;
        word_t       val;
        logic        pc_src;
        logic        chk_fpu;
        reg_addr_t   chk_reg;
        word_t       exp;
        logic        dev_early;
        logic        stall_exp;
    } row_t;

    logic        clk;
    logic        rst;
    logic        ex_valid;
    logic        ex_reg_write;
    logic        ex_fpu_reg_write;
    logic        ex_mem_write;
    result_src_t ex_result_src;
    reg_addr_t   ex_rd;
    word_t       ex_alu_result;
    word_t       ex_write_data;
    word_t       ex_pc_plus4;
    word_t       ex_rd1;
    word_t       ex_imm_ext;
    word_t       ex_fpu_rd1;
    word_t       ex_fpu_result;
    logic        pc_src_e;
    word_t       pc_target_e;
    word_t       pc_plus4_f;
    word_t       dev_data;
    logic        dev_valid;
    logic        dev_ready;
    logic        in_stall;
    word_t       instr_addr;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    reg_addr_t   fs1_addr;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       fs1_data;

    row_t        rows[$];
    string       names[$];
    // what the data RAM should hold, updated as stores are issued
    word_t       ref_ram [`CORE_DMEM_WORDS];
    // words handed to the device model and how many it has delivered
    word_t       dev_words[$];
    int          dev_posted = 0;
    int          dev_sent = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    bit          table_ready = 1'b0;

    backend_top backend_top_i (.*);

    bind backend_top backend_checker backend_checker_i (
        .clk, .rst, .mem_valid, .in_stall,
        .wb_valid (control_mem_if.valid),
        .wb_src   (control_mem_if.result_src),
        .reg_write_w, .fpu_reg_write_w, .dev_ready,
        .fifo_count (in_port_i.count),
        .in_data
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // the budget grows with the table, a stalled row takes a few extra cycles
    initial begin : watchdog
        wait (table_ready);
        repeat (rows.size() * 20 + 200) @(posedge clk);
        $display("run timed out after %0d clock periods", rows.size() * 20 + 200);
        $display("TEST FAILED");
        $finish;
    end

    // device side of the valid/ready handshake, one word per posted entry
    initial begin : device_model
        int gap;
        bit accepted;
        dev_valid = 1'b0;
        dev_data  = '0;
        forever begin
            wait (dev_sent < dev_posted);
            // at least one idle edge, so a word posted at issue always arrives late
            gap = $urandom_range(3, 1);
            repeat (gap) @(posedge clk);
            #2;
            dev_valid = 1'b1;
            dev_data  = dev_words[dev_sent];
            accepted  = 1'b0;
            while (!accepted) begin
                accepted = dev_ready;
                @(posedge clk);
                #2;
            end
            dev_valid = 1'b0;
            dev_data  = $urandom;
            dev_sent++;
        end
    end

    task automatic add_row(input string name, input logic valid, input logic reg_write,
                           input logic fpu_reg_write, input logic mem_write,
                           input result_src_t src, input reg_addr_t rd, input word_t alu,
                           input word_t val, input logic pc_src, input logic chk_fpu,
                           input reg_addr_t chk_reg, input word_t exp,
                           input logic dev_early, input logic stall_exp);
        names.push_back(name);
        rows.push_back(row_t'{valid, reg_write, fpu_reg_write, mem_write, src, rd, alu,
                              val, pc_src, chk_fpu, chk_reg, exp, dev_early, stall_exp});
    endtask

    task automatic drive_bubble();
        ex_valid         = 1'b0;
        ex_reg_write     = 1'b0;
        ex_fpu_reg_write = 1'b0;
        ex_mem_write     = 1'b0;
        ex_result_src    = RES_ALU;
    endtask

    // every read port of both banks must show zero straight after reset
    // and the input port starts with no stall and room for the device
    task automatic check_reset_clear();
        bit ok;
        ok = 1'b1;
        if (in_stall !== 1'b0) begin
            $display("FAILED reset_clear in_stall expected %0b actual %0b", 1'b0, in_stall);
            ok = 1'b0;
        end
        if (dev_ready !== 1'b1) begin
            $display("FAILED reset_clear dev_ready expected %0b actual %0b", 1'b1, dev_ready);
            ok = 1'b0;
        end
        for (int a = 0; a < `CORE_NREGS; a++) begin
            rs1_addr = reg_addr_t'(a);
            rs2_addr = reg_addr_t'(a);
            fs1_addr = reg_addr_t'(a);
            #1;
            if (rs1_data !== '0 || rs2_data !== '0 || fs1_data !== '0) begin
                $display("FAILED reset_clear reg %0d expected %h actual %h %h %h",
                         a, 32'h0, rs1_data, rs2_data, fs1_data);
                ok = 1'b0;
            end
        end
        if (ok) begin
            $display("PASSED reset_clear expected %h actual %h", 32'h0, 32'h0);
            tests_passed++;
        end else begin
            tests_failed++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic run_row(input int i);
        row_t  r;
        word_t target;
        word_t plus4;
        word_t exp;
        word_t exp_addr;
        word_t got;
        bit    stall_seen;
        bit    ok;
        int    wanted;
        r   = rows[i];
        ok  = 1'b1;
        exp = r.exp;
        // an early word sits in the buffer before issue, a late one forces a stall
        if (r.valid && r.src == RES_IN) begin
            dev_words.push_back(r.val);
            dev_posted++;
            wanted = dev_posted;
            if (r.dev_early) begin
                wait (dev_sent == wanted);
            end
        end
        // the RAM is word addressed by bits 9:2 of the address
        if (r.valid && r.mem_write) begin
            ref_ram[r.alu[9:2]] = r.val;
        end
        if (r.src == RES_LOAD) begin
            exp = ref_ram[r.alu[9:2]];
        end
        target   = $urandom;
        plus4    = $urandom;
        exp_addr = r.pc_src ? target : plus4;

        // sources that are not selected carry random decoys
        ex_valid         = r.valid;
        ex_reg_write     = r.reg_write;
        ex_fpu_reg_write = r.fpu_reg_write;
        ex_mem_write     = r.mem_write;
        ex_result_src    = r.src;
        ex_rd            = r.rd;
        ex_alu_result    = r.alu;
        ex_write_data    = r.val;
        ex_pc_plus4      = (r.src == RES_PC4) ? r.val : $urandom;
        ex_rd1           = (r.src == RES_RD1) ? r.val : $urandom;
        ex_imm_ext       = (r.src == RES_IMM) ? r.val : $urandom;
        ex_fpu_rd1       = (r.src == RES_FPU_RD1) ? r.val : $urandom;
        ex_fpu_result    = (r.src == RES_FPU) ? r.val : $urandom;
        pc_src_e         = r.pc_src;
        pc_target_e      = target;
        pc_plus4_f       = plus4;
        rs1_addr         = r.chk_reg;
        rs2_addr         = r.chk_reg;
        fs1_addr         = r.chk_reg;

        @(negedge clk);
        if (instr_addr !== exp_addr) begin
            $display("FAILED %s instr_addr expected %h actual %h", names[i], exp_addr, instr_addr);
            ok = 1'b0;
        end

        // the instruction is in EX/MEM now and is held there while stalled
        @(posedge clk);
        #2;
        stall_seen = 1'b0;
        while (in_stall) begin
            stall_seen = 1'b1;
            @(posedge clk);
            #2;
        end
        if (stall_seen != r.stall_exp) begin
            $display("FAILED %s in_stall expected %0d actual %0d", names[i], r.stall_exp,
                     stall_seen);
            ok = 1'b0;
        end
        drive_bubble();

        // one edge into MEM/WB, one more for the register write
        repeat (2) @(posedge clk);
        #2;
        got = r.chk_fpu ? fs1_data : rs1_data;
        if (got !== exp) begin
            $display("FAILED %s expected %h actual %h", names[i], exp, got);
            ok = 1'b0;
        end
        if (!r.chk_fpu && rs2_data !== exp) begin
            $display("FAILED %s rs2 expected %h actual %h", names[i], exp, rs2_data);
            ok = 1'b0;
        end
        if (ok) begin
            $display("PASSED %s expected %h actual %h", names[i], exp, got);
            tests_passed++;
        end else begin
            tests_failed++;
        end
    endtask

    initial begin : main
        void'($urandom(32'hfab0_94d3));
        rst         = 1'b1;
        drive_bubble();
        ex_rd       = '0;
        ex_alu_result = '0;
        ex_write_data = '0;
        ex_pc_plus4 = '0;
        ex_rd1      = '0;
        ex_imm_ext  = '0;
        ex_fpu_rd1  = '0;
        ex_fpu_result = '0;
        pc_src_e    = 1'b0;
        pc_target_e = '0;
        pc_plus4_f  = '0;
        rs1_addr    = '0;
        rs2_addr    = '0;
        fs1_addr    = '0;

        // name, valid, wr, fwr, mw, source, rd, alu, value, pc_src,
        // check fpu, check reg, expected, word early, stall expected
        add_row("alu_x1", 1'b1, 1'b1, 1'b0, 1'b0, RES_ALU, 5'd1, 32'h1234_5678, 32'h0,
                1'b0, 1'b0, 5'd1, 32'h1234_5678, 1'b0, 1'b0);
        add_row("store_no_write", 1'b1, 1'b0, 1'b0, 1'b1, RES_ALU, 5'd5, 32'h0000_0040,
                32'hcafe_f00d, 1'b1, 1'b0, 5'd5, 32'h0, 1'b0, 1'b0);
        add_row("load_x6", 1'b1, 1'b1, 1'b0, 1'b0, RES_LOAD, 5'd6, 32'h0000_0040, 32'h0,
                1'b0, 1'b0, 5'd6, 32'h0, 1'b0, 1'b0);
        add_row("pc4_x7", 1'b1, 1'b1, 1'b0, 1'b0, RES_PC4, 5'd7, 32'h0, 32'h0000_1004,
                1'b1, 1'b0, 5'd7, 32'h0000_1004, 1'b0, 1'b0);
        add_row("rd1_x8", 1'b1, 1'b1, 1'b0, 1'b0, RES_RD1, 5'd8, 32'h0, 32'h8765_4321,
                1'b0, 1'b0, 5'd8, 32'h8765_4321, 1'b0, 1'b0);
        add_row("imm_x9", 1'b1, 1'b1, 1'b0, 1'b0, RES_IMM, 5'd9, 32'h0, 32'habcd_e000,
                1'b1, 1'b0, 5'd9, 32'habcd_e000, 1'b0, 1'b0);
        add_row("fmv_f9", 1'b1, 1'b0, 1'b1, 1'b0, RES_FPU_RD1, 5'd9, 32'h0, 32'h3f80_0000,
                1'b0, 1'b1, 5'd9, 32'h3f80_0000, 1'b0, 1'b0);
        add_row("fpu_f10", 1'b1, 1'b0, 1'b1, 1'b0, RES_FPU, 5'd10, 32'h0, 32'h4049_0fdb,
                1'b1, 1'b1, 5'd10, 32'h4049_0fdb, 1'b0, 1'b0);
        add_row("fpu_not_int_x10", 1'b0, 1'b0, 1'b0, 1'b0, RES_ALU, 5'd10, 32'h0, 32'h0,
                1'b0, 1'b0, 5'd10, 32'h0, 1'b0, 1'b0);
        add_row("int_not_fpu_f1", 1'b0, 1'b0, 1'b0, 1'b0, RES_ALU, 5'd1, 32'h0, 32'h0,
                1'b1, 1'b1, 5'd1, 32'h0, 1'b0, 1'b0);
        add_row("in_stall_x11", 1'b1, 1'b1, 1'b0, 1'b0, RES_IN, 5'd11, 32'h0, 32'h0bad_beef,
                1'b0, 1'b0, 5'd11, 32'h0bad_beef, 1'b0, 1'b1);
        add_row("in_ready_x12", 1'b1, 1'b1, 1'b0, 1'b0, RES_IN, 5'd12, 32'h0, 32'h1357_9bdf,
                1'b1, 1'b0, 5'd12, 32'h1357_9bdf, 1'b1, 1'b0);
        add_row("x0_kept", 1'b1, 1'b1, 1'b0, 1'b0, RES_ALU, 5'd0, 32'hffff_ffff, 32'h0,
                1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0);
        add_row("invalid_x3", 1'b0, 1'b1, 1'b0, 1'b0, RES_ALU, 5'd3, 32'hdead_beef, 32'h0,
                1'b1, 1'b0, 5'd3, 32'h0, 1'b0, 1'b0);
        add_row("store_top", 1'b1, 1'b0, 1'b0, 1'b1, RES_ALU, 5'd13, 32'h0000_03fc,
                32'h5a5a_a5a5, 1'b0, 1'b0, 5'd13, 32'h0, 1'b0, 1'b0);
        add_row("load_x13", 1'b1, 1'b1, 1'b0, 1'b0, RES_LOAD, 5'd13, 32'h0000_03fc, 32'h0,
                1'b1, 1'b0, 5'd13, 32'h0, 1'b0, 1'b0);
        // 0x440 and 0x40 share bits 9:2, so this overwrites the first store
        add_row("store_alias", 1'b1, 1'b0, 1'b0, 1'b1, RES_ALU, 5'd14, 32'h0000_0440,
                32'h0123_4567, 1'b0, 1'b0, 5'd14, 32'h0, 1'b0, 1'b0);
        add_row("load_x14", 1'b1, 1'b1, 1'b0, 1'b0, RES_LOAD, 5'd14, 32'h0000_0040, 32'h0,
                1'b1, 1'b0, 5'd14, 32'h0, 1'b0, 1'b0);
        add_row("in_stall_f15", 1'b1, 1'b0, 1'b1, 1'b0, RES_IN, 5'd15, 32'h0, 32'h7f7f_0001,
                1'b0, 1'b1, 5'd15, 32'h7f7f_0001, 1'b0, 1'b1);
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        check_reset_clear();
        foreach (rows[i]) begin
            run_row(i);
        end

        $display("passed %0d, failed %0d, assertion failures %0d", tests_passed,
                 tests_failed, backend_top_i.backend_checker_i.assert_fails);
        if (tests_failed == 0 && backend_top_i.backend_checker_i.assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule
